// File: bender.yml
package:
  name: rainbow_circles

sources:
  - include_dirs:
      - logic
    files:
      - logic/gfx_pkg.sv
      - logic/draw_port_if.sv
      - logic/display_timings.sv
      - logic/draw_circle_fill.sv
      - logic/framebuffer.sv
      - logic/shape_sequencer.sv
      - logic/rainbow_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/rainbow_assertions.sv
      - tb/rainbow_tb.sv

// File: logic/display_timings.sv
// display timing generator
// raster counters with sync, active area and frame/line pulses
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defines.svh"

module display_timings (
    input  wire logic             clk_100m,
    input  wire logic             rst_n,
    output      gfx_pkg::coord_t  sx,     // horizontal position
    output      gfx_pkg::coord_t  sy,     // vertical position
    output      logic             hsync,
    output      logic             vsync,
    output      logic             de,     // active picture
    output      logic             frame,  // start of frame
    output      logic             line    // start of line
);

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == `GFX_H_TOTAL - 1) begin
            sx <= '0;
            if (sy == `GFX_V_TOTAL - 1) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode from the counters, active high syncs
    always_comb begin
        hsync = (sx >= `GFX_H_SYNC_START) && (sx < `GFX_H_SYNC_END);
        vsync = (sy >= `GFX_V_SYNC_START) && (sy < `GFX_V_SYNC_END);
        de    = (sx < `GFX_FB_WIDTH) && (sy < `GFX_FB_HEIGHT);  // unscaled picture
        frame = (sx == 0) && (sy == 0);
        line  = (sx == 0);
    end

endmodule

`default_nettype wire

// File: logic/draw_circle_fill.sv
// filled circle engine
// midpoint circle stepping, four horizontal spans per step, one pixel per oe cycle
`timescale 1ns/1ps
`default_nettype none

module draw_circle_fill (
    input  wire logic             clk_100m,
    input  wire logic             rst_n,
    input  wire logic             start,     // load centre and radius
    input  wire logic             oe,        // allowed to write this cycle
    input  wire gfx_pkg::coord_t  x0,
    input  wire gfx_pkg::coord_t  y0,
    input  wire gfx_pkg::coord_t  r0,
    draw_port_if.writer           draw_port,
    output      logic             drawing,
    output      logic             done
);

    typedef enum logic [1:0] {
        IDLE,
        FILL,   // sweeping a span
        STEP    // advance the midpoint decision
    } state_e;

    state_e state;

    gfx_pkg::coord_t xc, yc;       // latched centre
    gfx_pkg::coord_t xa, ya;       // current octant point
    gfx_pkg::coord_t dv;           // decision variable
    gfx_pkg::coord_t px, py;       // pixel being drawn
    gfx_pkg::coord_t px_end;       // right end of span
    logic [1:0]      span;         // which of the four spans
    gfx_pkg::coord_t nx, ny, nd;   // next step values

    // row of span s for octant point (a, b)
    function automatic gfx_pkg::coord_t span_row(input logic [1:0] s, input gfx_pkg::coord_t cy,
                                                 input gfx_pkg::coord_t a,
                                                 input gfx_pkg::coord_t b);
        case (s)
            2'd0:    return cy - b;
            2'd1:    return cy + b;
            2'd2:    return cy - a;
            default: return cy + a;
        endcase
    endfunction

    // half width of span s
    function automatic gfx_pkg::coord_t span_half(input logic [1:0] s, input gfx_pkg::coord_t a,
                                                  input gfx_pkg::coord_t b);
        return s[1] ? b : a;
    endfunction

    always_comb begin
        nx = xa + 1'b1;
        if (dv > 0) begin
            ny = ya - 1'b1;
            nd = gfx_pkg::coord_t'(dv + 4 * (nx - ny) + 10);
        end else begin
            ny = ya;
            nd = gfx_pkg::coord_t'(dv + 4 * nx + 6);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (oe && px == px_end && span == 2'd3) begin
                        state <= STEP;
                    end
                end
                STEP: begin
                    if (nx <= ny) begin
                        state <= FILL;
                    end else begin
                        state <= IDLE;
                        done  <= 1'b1;  // circle finished
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // step and span registers
    always_ff @(posedge clk_100m) begin
        if (state == IDLE && start) begin
            xc     <= x0;
            yc     <= y0;
            xa     <= '0;
            ya     <= r0;
            dv     <= gfx_pkg::coord_t'(3 - 2 * r0);
            span   <= 2'd0;
            px     <= x0;  // x = 0 so span 0 is a single pixel
            px_end <= x0;
            py     <= y0 - r0;
        end else if (state == FILL && oe) begin
            if (px == px_end) begin
                span   <= span + 1'b1;
                px     <= xc - span_half(span + 1'b1, xa, ya);
                px_end <= xc + span_half(span + 1'b1, xa, ya);
                py     <= span_row(span + 1'b1, yc, xa, ya);
            end else begin
                px <= px + 1'b1;
            end
        end else if (state == STEP) begin
            xa     <= nx;
            ya     <= ny;
            dv     <= nd;
            span   <= 2'd0;
            px     <= xc - span_half(2'd0, nx, ny);
            px_end <= xc + span_half(2'd0, nx, ny);
            py     <= span_row(2'd0, yc, nx, ny);
        end
    end

    assign draw_port.we = (state == FILL) && oe;
    assign draw_port.x  = px;
    assign draw_port.y  = py;
    assign drawing      = draw_port.we;

endmodule

`default_nettype wire

// File: logic/draw_port_if.sv
// pixel write port
// carries draw coordinates and colour to the framebuffer, busy back
`timescale 1ns/1ps
`default_nettype none

interface draw_port_if;

    logic             we;    // write this cycle
    gfx_pkg::coord_t  x;
    gfx_pkg::coord_t  y;
    gfx_pkg::cidx_t   cidx;  // colour set by the sequencer
    logic             busy;  // memory port taken by clear or scan-out

    modport writer (
        output we,
        output x,
        output y
    );

    modport fb (
        input  we,
        input  x,
        input  y,
        input  cidx,
        output busy
    );

endinterface

`default_nettype wire

// File: logic/framebuffer.sv
// framebuffer
// single-port index memory with clear sweep, clipped writes, scan-out and palette
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defines.svh"

module framebuffer (
    input  wire logic             clk_100m,
    input  wire logic             rst_n,
    draw_port_if.fb               draw_port,
    input  wire logic             de,
    input  wire gfx_pkg::coord_t  sx,
    input  wire gfx_pkg::coord_t  sy,
    input  wire logic             hsync,
    input  wire logic             vsync,
    output      gfx_pkg::chan_t   vid_red,
    output      gfx_pkg::chan_t   vid_green,
    output      gfx_pkg::chan_t   vid_blue,
    output      logic             vid_de,
    output      logic             vid_hsync,
    output      logic             vid_vsync
);

    localparam int FB_DEPTH = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;

    gfx_pkg::cidx_t   mem [FB_DEPTH];

    logic              clearing;   // reset sweep in progress
    gfx_pkg::fb_addr_t clr_addr;
    gfx_pkg::fb_addr_t scan_addr;
    gfx_pkg::fb_addr_t wr_addr;
    gfx_pkg::fb_addr_t mem_addr;   // the one memory port
    logic              wr_ok;
    logic              mem_we;
    gfx_pkg::cidx_t    mem_wdata;
    gfx_pkg::cidx_t    rd_cidx;

    // 8-bit level per index bit, bit 3 selects full brightness
    function automatic gfx_pkg::chan_t pal_chan(input logic on, input logic bright);
        if (!on) begin
            return '0;
        end
        return bright ? '1 : {1'b1, {(`GFX_CHANW-1){1'b0}}};
    endfunction

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            if (clr_addr == gfx_pkg::fb_addr_t'(FB_DEPTH - 1)) begin
                clearing <= 1'b0;
            end else begin
                clr_addr <= clr_addr + 1'b1;
            end
        end
    end

    always_comb begin
        scan_addr = gfx_pkg::fb_addr_t'(sy * `GFX_FB_WIDTH + sx);
        wr_addr   = gfx_pkg::fb_addr_t'(draw_port.y * `GFX_FB_WIDTH + draw_port.x);
        wr_ok     = draw_port.we &&
                    (draw_port.x >= 0) && (draw_port.x < `GFX_FB_WIDTH) &&
                    (draw_port.y >= 0) && (draw_port.y < `GFX_FB_HEIGHT);  // clip
        // clear first, then scan-out, then drawing
        if (clearing) begin
            mem_addr = clr_addr;
        end else if (de) begin
            mem_addr = scan_addr;
        end else begin
            mem_addr = wr_addr;
        end
        mem_we    = clearing || (wr_ok && !de);
        mem_wdata = clearing ? '0 : draw_port.cidx;
        rd_cidx   = mem[mem_addr];
    end

    assign draw_port.busy = clearing || de;

    always_ff @(posedge clk_100m) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // one cycle behind the raster
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            vid_de    <= 1'b0;
            vid_hsync <= 1'b0;
            vid_vsync <= 1'b0;
            vid_red   <= '0;
            vid_green <= '0;
            vid_blue  <= '0;
        end else begin
            vid_de    <= de;
            vid_hsync <= hsync;
            vid_vsync <= vsync;
            if (de && !clearing) begin
                vid_red   <= pal_chan(rd_cidx[2], rd_cidx[3]);
                vid_green <= pal_chan(rd_cidx[1], rd_cidx[3]);
                vid_blue  <= pal_chan(rd_cidx[0], rd_cidx[3]);
            end else begin
                vid_red   <= '0;  // blank, or black while clearing
                vid_green <= '0;
                vid_blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/gfx_defines.svh
// graphics demo constants
// framebuffer geometry, raster timing, scene layout and draw pacing
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

`define GFX_CORDW         16    // signed coordinate width
`define GFX_CIDXW         4     // colour index width
`define GFX_CHANW         8     // colour channel width

`define GFX_FB_WIDTH      64
`define GFX_FB_HEIGHT     36

`define GFX_H_TOTAL       80    // pixels per line
`define GFX_H_SYNC_START  68
`define GFX_H_SYNC_END    71
`define GFX_V_TOTAL       45    // lines per frame
`define GFX_V_SYNC_START  38
`define GFX_V_SYNC_END    39

`define GFX_SHAPE_CNT     8     // nested circles
`define GFX_CX            32
`define GFX_CY            36
`define GFX_R0            28    // outermost radius
`define GFX_RSTEP         3

`define GFX_FRAME_WAIT    2     // frames before drawing starts
`define GFX_PIX_FRAME     300   // oe cycles granted per frame

`endif

// File: logic/gfx_pkg.sv
// graphics demo types
// shared vector typedefs and the sequencer state encoding
`default_nettype none

`include "gfx_defines.svh"

package gfx_pkg;

    typedef logic signed [`GFX_CORDW-1:0] coord_t;  // screen coordinate
    typedef logic [`GFX_CIDXW-1:0] cidx_t;          // palette index
    typedef logic [`GFX_CHANW-1:0] chan_t;          // one colour channel
    typedef logic [11:0] fb_addr_t;                 // framebuffer word address
    typedef logic [3:0] shape_id_t;                 // which circle is drawn

    // top level drawing control
    typedef enum logic [1:0] {
        IDLE,   // waiting for the start frames
        INIT,   // load next circle
        DRAW,   // engine running
        DONE    // scene complete
    } seq_state_e;

endpackage

`default_nettype wire

// File: logic/rainbow_top.sv
// rainbow circles top level
// draws nested filled circles into the framebuffer and outputs parallel video
`timescale 1ns/1ps
`default_nettype none

module rainbow_top (
    input  wire logic            clk_100m,
    input  wire logic            rst_n,
    output      gfx_pkg::chan_t  vid_red,
    output      gfx_pkg::chan_t  vid_green,
    output      gfx_pkg::chan_t  vid_blue,
    output      logic            vid_de,
    output      logic            vid_hsync,
    output      logic            vid_vsync,
    output      logic            draw_complete
);

    gfx_pkg::coord_t sx, sy;
    logic            hsync, vsync, de, frame;
    logic            draw_start, draw_oe, draw_done;
    gfx_pkg::coord_t vx0, vy0, vr0;  // circle centre and radius

    draw_port_if draw_if ();

    display_timings display_timings_inst (
        .clk_100m,
        .rst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame,
        .line      ()
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m,
        .rst_n,
        .frame,
        .busy          (draw_if.busy),
        .done          (draw_done),
        .start         (draw_start),
        .oe            (draw_oe),
        .x0            (vx0),
        .y0            (vy0),
        .r0            (vr0),
        .cidx          (draw_if.cidx),
        .draw_complete
    );

    draw_circle_fill draw_circle_inst (
        .clk_100m,
        .rst_n,
        .start     (draw_start),
        .oe        (draw_oe),
        .x0        (vx0),
        .y0        (vy0),
        .r0        (vr0),
        .draw_port (draw_if.writer),
        .drawing   (),
        .done      (draw_done)
    );

    framebuffer fb_inst (
        .clk_100m,
        .rst_n,
        .draw_port (draw_if.fb),
        .de,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .vid_red,
        .vid_green,
        .vid_blue,
        .vid_de,
        .vid_hsync,
        .vid_vsync
    );

endmodule

`default_nettype wire

// File: logic/shape_sequencer.sv
// shape sequencer
// steps through the nested circles and paces the engine per frame
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defines.svh"

module shape_sequencer (
    input  wire logic             clk_100m,
    input  wire logic             rst_n,
    input  wire logic             frame,
    input  wire logic             busy,
    input  wire logic             done,
    output      logic             start,
    output      logic             oe,
    output      gfx_pkg::coord_t  x0,
    output      gfx_pkg::coord_t  y0,
    output      gfx_pkg::coord_t  r0,
    output      gfx_pkg::cidx_t   cidx,
    output      logic             draw_complete
);

    localparam int WAIT_W = $clog2(`GFX_FRAME_WAIT + 1);
    localparam int PIX_W  = $clog2(`GFX_PIX_FRAME + 1);

    gfx_pkg::seq_state_e state;
    gfx_pkg::shape_id_t  shape_id;
    logic [WAIT_W-1:0]   wait_cnt;  // frames seen since reset
    logic [PIX_W-1:0]    pix_cnt;   // oe cycles used this frame

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state    <= gfx_pkg::IDLE;
            shape_id <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                gfx_pkg::IDLE: begin
                    if (wait_cnt == WAIT_W'(`GFX_FRAME_WAIT)) begin
                        state <= gfx_pkg::INIT;
                    end
                end
                gfx_pkg::INIT: begin
                    start <= 1'b1;
                    state <= gfx_pkg::DRAW;
                end
                gfx_pkg::DRAW: begin
                    if (done) begin
                        if (shape_id == `GFX_SHAPE_CNT - 1) begin
                            state <= gfx_pkg::DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= gfx_pkg::INIT;
                        end
                    end
                end
                default: state <= gfx_pkg::DONE;  // hold until reset
            endcase
        end
    end

    // circle parameters, stable for the whole draw
    always_ff @(posedge clk_100m) begin
        if (state == gfx_pkg::INIT) begin
            x0   <= gfx_pkg::coord_t'(`GFX_CX);
            y0   <= gfx_pkg::coord_t'(`GFX_CY);
            r0   <= gfx_pkg::coord_t'(`GFX_R0 - `GFX_RSTEP * shape_id);
            cidx <= (shape_id == `GFX_SHAPE_CNT - 1) ? '0 : gfx_pkg::cidx_t'(8 + shape_id);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            pix_cnt  <= '0;
        end else begin
            if (frame && wait_cnt != WAIT_W'(`GFX_FRAME_WAIT)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (frame) begin
                pix_cnt <= '0;  // new budget
            end else if (oe) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // only when the memory port is free
    assign oe = (state == gfx_pkg::DRAW) && (pix_cnt != PIX_W'(`GFX_PIX_FRAME)) && !busy;
    assign draw_complete = (state == gfx_pkg::DONE);

endmodule

`default_nettype wire

// File: tb/rainbow_assertions.sv
// draw port and video output assertions
// bound into the top level, covering the circle engine and the framebuffer
`timescale 1ns/1ps
`default_nettype none

module rainbow_assertions (
    input wire logic       clk_100m,
    input wire logic       rst_n,
    input wire logic       we,
    input wire logic       busy,
    input wire logic       done,
    input wire logic       vid_de,
    input wire logic [7:0] vid_red,
    input wire logic [7:0] vid_green,
    input wire logic [7:0] vid_blue
);

    int fails = 0;  // failed assertion count

    // memory port belongs to clear or scan-out while busy
    write_when_free: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !(we && busy))
    else begin
        $error("pixel write while framebuffer busy");
        fails++;
    end

    done_single: assert property (@(posedge clk_100m) disable iff (!rst_n)
        done |=> !done)
    else begin
        $error("done held for more than one cycle");
        fails++;
    end

    blank_black: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !vid_de |-> (vid_red == 8'd0 && vid_green == 8'd0 && vid_blue == 8'd0))
    else begin
        $error("colour outside the active picture");
        fails++;
    end

endmodule

bind rainbow_top rainbow_assertions rainbow_checks (
    .clk_100m  (clk_100m),
    .rst_n     (rst_n),
    .we        (draw_if.we),
    .busy      (draw_if.busy),
    .done      (draw_done),
    .vid_de    (vid_de),
    .vid_red   (vid_red),
    .vid_green (vid_green),
    .vid_blue  (vid_blue)
);

`default_nettype wire

// File: tb/rainbow_tb.sv
// rainbow circles testbench
// checks raster timing and captured frames against a model of the scene
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defines.svh"

module rainbow_tb;

    localparam int FB_PIX        = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;
    localparam int FRAME_CYC     = `GFX_H_TOTAL * `GFX_V_TOTAL;
    localparam int DRAW_TIMEOUT  = 200 * FRAME_CYC;  // whole scene, with margin
    localparam int CHECK_CLEAR   = 0;
    localparam int CHECK_PARTIAL = 1;
    localparam int CHECK_FINAL   = 2;

    logic        clk_100m;
    logic        rst_n;
    logic [7:0]  vid_red;
    logic [7:0]  vid_green;
    logic [7:0]  vid_blue;
    logic        vid_de;
    logic        vid_hsync;
    logic        vid_vsync;
    logic        draw_complete;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          mid_frames;       // partial frames captured per pass
    int          exp_idx [FB_PIX];  // final colour index per pixel
    logic [15:0] allowed [FB_PIX];  // indices any shape leaves at a pixel

    rainbow_top UUT (
        .clk_100m      (clk_100m),
        .rst_n         (rst_n),
        .vid_red       (vid_red),
        .vid_green     (vid_green),
        .vid_blue      (vid_blue),
        .vid_de        (vid_de),
        .vid_hsync     (vid_hsync),
        .vid_vsync     (vid_vsync),
        .draw_complete (draw_complete)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // index bits 2..0 pick red, green, blue; bit 3 picks full level
    function automatic logic [7:0] chan_level(input logic on, input logic bright);
        if (!on) begin
            return 8'd0;
        end
        return bright ? 8'd255 : 8'd128;
    endfunction

    function automatic logic [23:0] palette_rgb(input int idx);
        logic [3:0] i;
        i = idx[3:0];
        return {chan_level(i[2], i[3]), chan_level(i[1], i[3]), chan_level(i[0], i[3])};
    endfunction

    task automatic paint_span(input int row, input int left, input int right, input int ci);
        int col;
        int addr;
        if (row < 0 || row >= `GFX_FB_HEIGHT) begin
            return;  // clipped row
        end
        for (col = left; col <= right; col++) begin
            if (col >= 0 && col < `GFX_FB_WIDTH) begin
                addr          = row * `GFX_FB_WIDTH + col;
                exp_idx[addr] = ci;
                allowed[addr] = allowed[addr] | (16'd1 << ci);
            end
        end
    endtask

    // midpoint circles, later shapes on top
    task automatic build_model();
        int k, r, ci, x, y, d, a;
        for (a = 0; a < FB_PIX; a++) begin
            exp_idx[a] = 0;
            allowed[a] = '0;
        end
        for (k = 0; k < `GFX_SHAPE_CNT; k++) begin
            r  = `GFX_R0 - `GFX_RSTEP * k;
            ci = (k == `GFX_SHAPE_CNT - 1) ? 0 : 8 + k;
            x  = 0;
            y  = r;
            d  = 3 - 2 * r;
            while (x <= y) begin
                paint_span(`GFX_CY - y, `GFX_CX - x, `GFX_CX + x, ci);
                paint_span(`GFX_CY + y, `GFX_CX - x, `GFX_CX + x, ci);
                paint_span(`GFX_CY - x, `GFX_CX - y, `GFX_CX + y, ci);
                paint_span(`GFX_CY + x, `GFX_CX - y, `GFX_CX + y, ci);
                x++;
                if (d > 0) begin
                    y--;
                    d = d + 4 * (x - y) + 10;
                end else begin
                    d = d + 4 * x + 6;
                end
            end
        end
    endtask

    function automatic bit partial_ok(input int addr, input logic [23:0] rgb);
        int i;
        if (rgb == 24'd0) begin
            return 1'b1;
        end
        for (i = 0; i < 16; i++) begin
            if (allowed[addr][i] && palette_rgb(i) == rgb) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        errors += UUT.rainbow_checks.fails;
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk_100m);
        rst_n <= 1'b0;
        repeat (cycles) @(posedge clk_100m);
        rst_n <= 1'b1;
        @(negedge clk_100m);
        checks++;
        if (draw_complete !== 1'b0) begin
            report_mismatch("draw_complete still high after reset");
        end
    endtask

    // one video frame, raster shape checked on every cycle
    task automatic capture_frame(input bit sync_first, input int mode);
        int cnt, t, col, row, addr;
        logic        e_de, e_hs, e_vs;
        logic [23:0] rgb, exp_rgb;
        cnt = 0;
        while (sync_first && vid_vsync !== 1'b1 && cnt < FRAME_CYC) begin
            @(negedge clk_100m);
            cnt++;
        end
        if (sync_first && vid_vsync !== 1'b1) begin
            timeout_fail("vertical sync");
        end
        cnt = 0;
        while (vid_de !== 1'b1 && cnt < FRAME_CYC) begin
            @(negedge clk_100m);
            cnt++;
        end
        if (vid_de !== 1'b1) begin
            timeout_fail("start of the active picture");
        end
        for (t = 0; t < FRAME_CYC; t++) begin
            col  = t % `GFX_H_TOTAL;
            row  = t / `GFX_H_TOTAL;
            addr = row * `GFX_FB_WIDTH + col;
            e_de = (col < `GFX_FB_WIDTH) && (row < `GFX_FB_HEIGHT);
            e_hs = (col >= `GFX_H_SYNC_START) && (col < `GFX_H_SYNC_END);
            e_vs = (row >= `GFX_V_SYNC_START) && (row < `GFX_V_SYNC_END);
            rgb  = {vid_red, vid_green, vid_blue};
            checks++;
            if (vid_de !== e_de || vid_hsync !== e_hs || vid_vsync !== e_vs) begin
                report_mismatch($sformatf("raster at (%0d,%0d): de/hs/vs %b%b%b, expected %b%b%b",
                    col, row, vid_de, vid_hsync, vid_vsync, e_de, e_hs, e_vs));
            end
            exp_rgb = (e_de && mode == CHECK_FINAL) ? palette_rgb(exp_idx[addr]) : 24'd0;
            if (e_de && mode == CHECK_PARTIAL) begin
                if (!partial_ok(addr, rgb)) begin
                    report_mismatch($sformatf("pixel (%0d,%0d) shows %06h, not a shape colour",
                        col, row, rgb));
                end
            end else if (rgb !== exp_rgb) begin
                report_mismatch($sformatf("pixel (%0d,%0d) shows %06h, expected %06h",
                    col, row, rgb, exp_rgb));
            end
            @(negedge clk_100m);
        end
    endtask

    task automatic wait_draw_complete();
        int cnt;
        cnt = 0;
        while (draw_complete !== 1'b1 && cnt < DRAW_TIMEOUT) begin
            @(negedge clk_100m);
            cnt++;
        end
        if (draw_complete !== 1'b1) begin
            timeout_fail("draw_complete");
        end
    endtask

    task automatic run_scene(input bit mid_reset);
        int n, delay, len;
        apply_reset(16);
        capture_frame(1'b0, CHECK_CLEAR);
        for (n = 0; n < mid_frames; n++) begin
            capture_frame(1'b1, CHECK_PARTIAL);
        end
        if (mid_reset) begin
            random_bits(12, delay);
            random_bits(4, len);
            repeat (delay) @(posedge clk_100m);
            checks++;
            if (draw_complete !== 1'b0) begin
                report_mismatch("scene already complete before the mid-draw reset");
            end
            apply_reset(len + 1);
            capture_frame(1'b0, CHECK_CLEAR);
        end
        wait_draw_complete();
        capture_frame(1'b1, CHECK_FINAL);
    endtask

    initial begin
        rst_n  = 1'b0;
        lfsr   = 32'h3f495306;
        errors = 0;
        checks = 0;
        build_model();
        random_bits(2, mid_frames);
        mid_frames = mid_frames % 3 + 1;
        run_scene(1'b0);
        run_scene(1'b1);  // second pass with a reset while drawing
        finish_run();
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/gfx_pkg.sv
logic/draw_port_if.sv
logic/display_timings.sv
logic/draw_circle_fill.sv
logic/framebuffer.sv
logic/shape_sequencer.sv
logic/rainbow_top.sv
tb/rainbow_assertions.sv
tb/rainbow_tb.sv
